// File: Bender.yml
package:
  name: ext_subsys

sources:
  - common/ext_subsys_pkg.sv
  - rtl/obi_demux.sv
  - slow_mem/slow_mem_fifo.sv
  - slow_mem/slow_mem.sv
  - power_ctrl/power_domain_seq.sv
  - power_ctrl/power_ctrl_regs.sv
  - rtl/ext_subsys.sv
  - target: simulation
    files:
      - dv/ext_subsys_checker.sv
      - dv/tb_ext_subsys.sv

// File: common/ext_subsys_pkg.sv
//////////////////////////////////////////////////
// external subsystem shared definitions
// bus structs, address rule, power FSM states
//////////////////////////////////////////////////

package ext_subsys_pkg;

  // bus widths
  localparam int unsigned DATA_W = 32;
  localparam int unsigned BE_W   = 4;

  // status register keeps off flags low, on flags from this bit up
  localparam int unsigned NUM_DOMAINS_MAX = 16;

  // request driven by one master
  typedef struct packed {
    logic              req;
    logic              we;
    logic [BE_W-1:0]   be;
    logic [31:0]       addr;
    logic [DATA_W-1:0] wdata;
  } obi_req_t;

  // response driven by one target
  typedef struct packed {
    logic              gnt;
    logic              rvalid;
    logic [DATA_W-1:0] rdata;
  } obi_rsp_t;

  // demux select, also the tag of outstanding transactions
  typedef enum logic {
    TGT_MEM = 1'b0,
    TGT_PWR = 1'b1
  } target_e;

  // per-domain power sequencer states
  typedef enum logic [2:0] {
    PWR_ON      = 3'd0,
    PWR_ISO     = 3'd1,
    PWR_SW_OFF  = 3'd2,
    PWR_OFF     = 3'd3,
    PWR_SW_ON   = 3'd4,
    PWR_UNISO   = 3'd5,
    PWR_RST_REL = 3'd6
  } pwr_state_e;

  // control pins of one external domain, all active low
  typedef struct packed {
    logic switch_n;
    logic iso_n;
    logic rst_n;
  } pwr_ctrl_t;

  // power controller window, 4 KiB, everything else is memory
  localparam logic [31:0] PWR_BASE = 32'h0001_0000;
  localparam logic [31:0] PWR_MASK = 32'hFFFF_F000;

  // register offsets inside the power window
  localparam logic [11:0] PWR_REQ_OFFS    = 12'h000;
  localparam logic [11:0] PWR_STATUS_OFFS = 12'h004;
  localparam logic [11:0] PWR_ACK_OFFS    = 12'h008;

endpackage

// File: dv/ext_subsys_checker.sv
//////////////////////////////////////////////////
// external subsystem checker
// predicts responses, compares, watches power pins
//////////////////////////////////////////////////

`timescale 1ns/1ns

module ext_subsys_checker #(
  parameter int unsigned MEM_WORDS     = 1024,
  parameter int unsigned NUM_DOMAINS   = 2,
  parameter int unsigned ACTIVE_DOMAIN = 0
) (
  input  logic                                        clk_i,
  input  logic                                        rst_n_i,
  input  ext_subsys_pkg::obi_req_t                    host_req_i,
  input  ext_subsys_pkg::obi_rsp_t                    host_rsp_i,
  input  ext_subsys_pkg::pwr_ctrl_t [NUM_DOMAINS-1:0] pwr_ctrl_i,
  input  logic [NUM_DOMAINS-1:0]                      switch_ack_n_i,
  input  logic [31:0]                                 exp_status_i,
  input  logic [8*16-1:0]                             test_name_i,
  output int                                          pending_o,
  output int                                          data_errors_o,
  output int                                          proto_errors_o,
  output int                                          seq_errors_o
);
  import ext_subsys_pkg::*;

  localparam int unsigned MAX_OUTSTANDING = 4;
  localparam pwr_ctrl_t   CTRL_ON = '{switch_n: 1'b0, iso_n: 1'b1, rst_n: 1'b1};

  typedef struct packed {
    logic [8*16-1:0]   name;
    logic [DATA_W-1:0] data;
  } expect_t;

  expect_t                     exp_q [$];
  logic [DATA_W-1:0]           ref_mem [MEM_WORDS];
  logic [NUM_DOMAINS-1:0]      ref_req = '0;
  pwr_ctrl_t [NUM_DOMAINS-1:0] prev_ctrl;
  int                          pending = 0;
  int                          data_errors = 0;
  int                          proto_errors = 0;
  int                          seq_errors = 0;

  assign pending_o      = pending;
  assign data_errors_o  = data_errors;
  assign proto_errors_o = proto_errors;
  assign seq_errors_o   = seq_errors;

  function automatic logic [DATA_W-1:0] merge_bytes(input logic [DATA_W-1:0] old_word,
                                                    input logic [DATA_W-1:0] new_word,
                                                    input logic [BE_W-1:0]   be);
    logic [DATA_W-1:0] w;
    w = old_word;
    for (int b = 0; b < BE_W; b++) begin
      if (be[b]) begin
        w[8*b +: 8] = new_word[8*b +: 8];
      end
    end
    return w;
  endfunction

  // updates the reference state and gives the response data
  task automatic predict_access(input obi_req_t r, output logic [DATA_W-1:0] rdata);
    int unsigned idx;
    rdata = '0;
    if ((r.addr & PWR_MASK) == PWR_BASE) begin
      if (r.we && (r.addr[11:0] == PWR_REQ_OFFS)) begin
        for (int d = 0; d < NUM_DOMAINS; d++) begin
          if (r.be[d/8]) begin
            ref_req[d] = r.wdata[d];
          end
        end
      end else if (!r.we) begin
        case (r.addr[11:0])
          PWR_REQ_OFFS:    rdata[NUM_DOMAINS-1:0] = ref_req;
          PWR_STATUS_OFFS: rdata = exp_status_i;
          PWR_ACK_OFFS:    rdata[NUM_DOMAINS-1:0] = switch_ack_n_i;
          default:         rdata = '0;
        endcase
      end
    end else begin
      idx = (r.addr >> 2) % MEM_WORDS;
      if (r.we) begin
        ref_mem[idx] = merge_bytes(ref_mem[idx], r.wdata, r.be);
      end else begin
        rdata = ref_mem[idx];
      end
    end
  endtask

  always @(posedge clk_i) begin : compare
    expect_t           e;
    logic [DATA_W-1:0] d;
    if (rst_n_i) begin
      // a response never belongs to a request accepted in the same cycle
      if (host_rsp_i.rvalid) begin
        if (exp_q.size() == 0) begin
          $display("ERROR: response at %0t with no outstanding request", $time);
          proto_errors++;
        end else begin
          e = exp_q.pop_front();
          if (host_rsp_i.rdata !== e.data) begin
            $display("CHECK FAILED test=%0s expected=%h actual=%h",
                     e.name, e.data, host_rsp_i.rdata);
            data_errors++;
          end
        end
      end
      if (host_req_i.req && host_rsp_i.gnt) begin
        predict_access(host_req_i, d);
        e.name = test_name_i;
        e.data = d;
        exp_q.push_back(e);
      end
      if (exp_q.size() > MAX_OUTSTANDING) begin
        $display("ERROR: %0d requests outstanding at %0t, more than %0d",
                 exp_q.size(), $time, MAX_OUTSTANDING);
        proto_errors++;
      end
      pending = exp_q.size();
    end else if (host_rsp_i.gnt || host_rsp_i.rvalid) begin
      $display("ERROR: gnt or rvalid high at %0t while in reset", $time);
      proto_errors++;
    end
  end

  // ordering of the power pins, one edge at a time
  always @(posedge clk_i) begin
    if (!rst_n_i) begin
      prev_ctrl <= {NUM_DOMAINS{CTRL_ON}};
    end else begin
      for (int d = 0; d < NUM_DOMAINS; d++) begin
        if ((d != ACTIVE_DOMAIN) && (pwr_ctrl_i[d] !== CTRL_ON)) begin
          $display("ERROR: domain %0d controls changed while it was never requested", d);
          seq_errors++;
        end
        if (exp_status_i[NUM_DOMAINS_MAX + d] && (pwr_ctrl_i[d] !== CTRL_ON)) begin
          $display("ERROR: domain %0d controls not all on while it should be on", d);
          seq_errors++;
        end
        if (pwr_ctrl_i[d].switch_n && !prev_ctrl[d].switch_n && prev_ctrl[d].iso_n) begin
          $display("ERROR: domain %0d switched off before it was isolated", d);
          seq_errors++;
        end
        if (pwr_ctrl_i[d].rst_n && !prev_ctrl[d].rst_n &&
            (!prev_ctrl[d].iso_n || prev_ctrl[d].switch_n)) begin
          $display("ERROR: domain %0d reset released before power-on and de-isolation", d);
          seq_errors++;
        end
      end
      prev_ctrl <= pwr_ctrl_i;
    end
  end

endmodule

// File: dv/tb_ext_subsys.sv
//////////////////////////////////////////////////
// external subsystem testbench
// stimulus, switch-cell model, expected power status
//////////////////////////////////////////////////

`timescale 1ns/1ns

module tb_ext_subsys;
  import ext_subsys_pkg::*;

  localparam int unsigned MEM_WORDS   = 1024;
  // long enough that reads hit the demux limit of four outstanding
  localparam int unsigned MEM_LATENCY = 4;
  localparam int unsigned NUM_DOMAINS = 2;
  localparam int unsigned NUM_ADDRS   = 32;
  localparam int unsigned ACK_DELAY   = 15;
  // about 400 transactions at 30 cycles worst case, plus power sequences
  localparam int unsigned TIMEOUT_CYCLES = 400 * 30 + 8000;

  logic                                  clk_i;
  logic                                  rst_n_i;
  obi_req_t                              host_req;
  obi_rsp_t                              host_rsp;
  pwr_ctrl_t [NUM_DOMAINS-1:0]           pwr_ctrl;
  logic [NUM_DOMAINS-1:0]                switch_ack_n;
  logic [NUM_DOMAINS-1:0][ACK_DELAY-1:0] ack_line;
  logic [NUM_DOMAINS-1:0]                dom_off;
  logic [NUM_DOMAINS-1:0]                dom_on;
  logic [DATA_W-1:0]                     exp_status;
  logic [8*16-1:0]                       test_name;
  logic [31:0]                           addr_list [NUM_ADDRS];
  int                                    pending;
  int                                    data_errors;
  int                                    proto_errors;
  int                                    seq_errors;
  int unsigned                           cycle_cnt = 0;
  integer                                seed;

  ext_subsys #(
    .MEM_WORDS  (MEM_WORDS),
    .MEM_LATENCY(MEM_LATENCY),
    .NUM_DOMAINS(NUM_DOMAINS)
  ) i_ext_subsys (
    .clk_i,
    .rst_n_i,
    .host_req_i    (host_req),
    .host_rsp_o    (host_rsp),
    .pwr_ctrl_o    (pwr_ctrl),
    .switch_ack_n_i(switch_ack_n)
  );

  ext_subsys_checker #(
    .MEM_WORDS    (MEM_WORDS),
    .NUM_DOMAINS  (NUM_DOMAINS),
    .ACTIVE_DOMAIN(0)
  ) i_ext_subsys_checker (
    .clk_i,
    .rst_n_i,
    .host_req_i    (host_req),
    .host_rsp_i    (host_rsp),
    .pwr_ctrl_i    (pwr_ctrl),
    .switch_ack_n_i(switch_ack_n),
    .exp_status_i  (exp_status),
    .test_name_i   (test_name),
    .pending_o     (pending),
    .data_errors_o (data_errors),
    .proto_errors_o(proto_errors),
    .seq_errors_o  (seq_errors)
  );

  initial clk_i = 1'b0;
  always #5 clk_i = ~clk_i;

  // switch cells answer a fixed number of cycles after the switch control
  always @(negedge clk_i) begin
    for (int d = 0; d < NUM_DOMAINS; d++) begin
      ack_line[d] <= {ack_line[d][ACK_DELAY-2:0], pwr_ctrl[d].switch_n};
    end
  end

  for (genvar d = 0; d < NUM_DOMAINS; d++) begin : gen_ack
    assign switch_ack_n[d] = ack_line[d][ACK_DELAY-1];
  end

  // off bits low, on bits from bit 16 up
  function automatic logic [DATA_W-1:0] expected_status(input logic [NUM_DOMAINS-1:0] off_done,
                                                        input logic [NUM_DOMAINS-1:0] on_done);
    logic [DATA_W-1:0] s;
    s = '0;
    for (int d = 0; d < NUM_DOMAINS; d++) begin
      s[d]                   = off_done[d];
      s[NUM_DOMAINS_MAX + d] = on_done[d];
    end
    return s;
  endfunction

  assign exp_status = expected_status(dom_off, dom_on);

  // word aligned, kept out of the power window
  function automatic logic [31:0] mem_alias(input logic [31:0] raw);
    logic [31:0] a;
    a = {raw[31:2], 2'b00};
    if ((a & PWR_MASK) == PWR_BASE) begin
      a[31] = 1'b1;
    end
    return a;
  endfunction

  always @(posedge clk_i) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= TIMEOUT_CYCLES) begin
      $display("timeout after %0d cycles, the DUT stopped responding", cycle_cnt);
      $display("Simulation failed");
      $finish;
    end
  end

  // called on a falling edge, returns on the falling edge after acceptance
  task automatic issue(input logic we, input logic [31:0] addr,
                       input logic [DATA_W-1:0] wdata, input logic [BE_W-1:0] be);
    host_req.req   = 1'b1;
    host_req.we    = we;
    host_req.be    = be;
    host_req.addr  = addr;
    host_req.wdata = we ? wdata : '0;
    // gnt is settled during the low half of the clock
    #1;
    while (!host_rsp.gnt) begin
      @(negedge clk_i);
      #1;
    end
    @(negedge clk_i);
  endtask

  task automatic drain();
    host_req = '0;
    while (pending != 0) begin
      @(negedge clk_i);
    end
  endtask

  initial begin
    logic [31:0] rnd;
    seed      = 32'hee39_a09c;
    rst_n_i   = 1'b0;
    host_req  = '0;
    ack_line  = '0;
    dom_off   = '0;
    dom_on    = '1;
    test_name = "reset";
    repeat (16) @(posedge clk_i);
    @(negedge clk_i);
    rst_n_i = 1'b1;
    @(negedge clk_i);

    test_name = "mem_write_read";
    for (int i = 0; i < NUM_ADDRS; i++) begin
      addr_list[i] = mem_alias($random(seed));
      issue(1'b1, addr_list[i], $random(seed), 4'hF);
    end
    for (int i = 0; i < NUM_ADDRS; i++) begin
      issue(1'b0, addr_list[i], '0, 4'hF);
    end
    drain();

    test_name = "byte_enables";
    for (int i = 0; i < NUM_ADDRS; i++) begin
      rnd = $random(seed);
      issue(1'b1, addr_list[i], $random(seed), rnd[BE_W-1:0]);
      issue(1'b0, addr_list[i], '0, 4'hF);
    end
    drain();

    // req stays high across the whole burst
    test_name = "pipelined_reads";
    repeat (2) begin
      for (int i = 0; i < NUM_ADDRS; i++) begin
        issue(1'b0, addr_list[NUM_ADDRS-1-i], '0, 4'hF);
      end
    end
    drain();

    // high addresses and the word just above the power window alias low words
    test_name = "default_decode";
    for (int i = 0; i < 8; i++) begin
      issue(1'b1, 32'hFFFF_F000 + 32'(4 * i), $random(seed), 4'hF);
      issue(1'b0, 32'(4 * i), '0, 4'hF);
      issue(1'b0, 32'h0001_1000 + 32'(4 * i), '0, 4'hF);
    end
    issue(1'b1, 32'h0000_FFFC, $random(seed), 4'hF);
    issue(1'b0, 32'h0000_0FFC, '0, 4'hF);
    drain();

    test_name = "power_seq";
    issue(1'b0, PWR_BASE + PWR_STATUS_OFFS, '0, 4'hF);
    issue(1'b1, PWR_BASE + PWR_REQ_OFFS, 32'h1, 4'hF);
    dom_on[0] = 1'b0;
    drain();
    while (!pwr_ctrl[0].switch_n) begin
      @(negedge clk_i);
    end
    // switch is open but the ack has not come back yet
    issue(1'b0, PWR_BASE + PWR_STATUS_OFFS, '0, 4'hF);
    issue(1'b0, PWR_BASE + PWR_REQ_OFFS, '0, 4'hF);
    issue(1'b0, PWR_BASE + PWR_ACK_OFFS, '0, 4'hF);
    drain();
    while (!switch_ack_n[0]) begin
      @(negedge clk_i);
    end
    repeat (3) @(negedge clk_i);
    dom_off[0] = 1'b1;
    issue(1'b0, PWR_BASE + PWR_STATUS_OFFS, '0, 4'hF);
    issue(1'b0, PWR_BASE + PWR_ACK_OFFS, '0, 4'hF);
    issue(1'b1, PWR_BASE + PWR_REQ_OFFS, 32'h0, 4'hF);
    dom_off[0] = 1'b0;
    drain();
    while (pwr_ctrl[0].switch_n) begin
      @(negedge clk_i);
    end
    issue(1'b0, PWR_BASE + PWR_STATUS_OFFS, '0, 4'hF);
    drain();
    while (switch_ack_n[0]) begin
      @(negedge clk_i);
    end
    // de-isolate and reset release follow the ack
    repeat (5) @(negedge clk_i);
    dom_on[0] = 1'b1;
    issue(1'b0, PWR_BASE + PWR_STATUS_OFFS, '0, 4'hF);
    drain();

    test_name = "mixed_targets";
    for (int i = 0; i < 16; i++) begin
      case (i % 4)
        0:       issue(1'b0, addr_list[i], '0, 4'hF);
        1:       issue(1'b0, PWR_BASE + PWR_STATUS_OFFS, '0, 4'hF);
        2:       issue(1'b1, addr_list[i], $random(seed), 4'hF);
        default: issue(1'b0, PWR_BASE + PWR_ACK_OFFS, '0, 4'hF);
      endcase
    end
    issue(1'b1, PWR_BASE + PWR_STATUS_OFFS, 32'hFFFF_FFFF, 4'hF);
    issue(1'b0, PWR_BASE + PWR_STATUS_OFFS, '0, 4'hF);
    issue(1'b0, PWR_BASE + 32'h010, '0, 4'hF);
    issue(1'b0, addr_list[0], '0, 4'hF);
    drain();

    repeat (4) @(negedge clk_i);
    $display("errors: %0d data, %0d protocol, %0d power sequence",
             data_errors, proto_errors, seq_errors);
    if (data_errors + proto_errors + seq_errors == 0) begin
      $display("Simulation completed successfully");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

// File: power_ctrl/power_ctrl_regs.sv
//////////////////////////////////////////////////
// power controller registers
// request, status and ack view, one FSM per domain
//////////////////////////////////////////////////

`timescale 1ns/1ns

module power_ctrl_regs #(
  parameter int unsigned NUM_DOMAINS = 2
) (
  input  logic                                         clk_i,
  input  logic                                         rst_n_i,
  input  ext_subsys_pkg::obi_req_t                     req_i,
  output ext_subsys_pkg::obi_rsp_t                     rsp_o,
  output ext_subsys_pkg::pwr_ctrl_t [NUM_DOMAINS-1:0]  pwr_ctrl_o,
  input  logic [NUM_DOMAINS-1:0]                       switch_ack_n_i
);
  import ext_subsys_pkg::*;

  logic [11:0]            offs;
  logic                   wr_req;
  logic [NUM_DOMAINS-1:0] off_req_q;
  logic [NUM_DOMAINS-1:0] is_off;
  logic [NUM_DOMAINS-1:0] is_on;
  logic [DATA_W-1:0]      status;
  logic [DATA_W-1:0]      rd_data;
  logic                   rvalid_q;
  logic [DATA_W-1:0]      rdata_q;

  assign offs   = req_i.addr[11:0];
  assign wr_req = req_i.req & req_i.we;

  // only the request register is writable
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      off_req_q <= '0;
    end else if (wr_req && (offs == PWR_REQ_OFFS)) begin
      for (int d = 0; d < NUM_DOMAINS; d++) begin
        if (req_i.be[d/8]) begin
          off_req_q[d] <= req_i.wdata[d];
        end
      end
    end
  end

  always_comb begin
    status = '0;
    for (int d = 0; d < NUM_DOMAINS; d++) begin
      status[d]                   = is_off[d];
      status[NUM_DOMAINS_MAX + d] = is_on[d];
    end
  end

  always_comb begin
    case (offs)
      PWR_REQ_OFFS:    rd_data = DATA_W'(off_req_q);
      PWR_STATUS_OFFS: rd_data = status;
      PWR_ACK_OFFS:    rd_data = DATA_W'(switch_ack_n_i);
      default:         rd_data = '0;
    endcase
  end

  // response one cycle after grant
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      rvalid_q <= 1'b0;
    end else begin
      rvalid_q <= req_i.req;
    end
  end

  always_ff @(posedge clk_i) begin
    if (req_i.req) begin
      rdata_q <= req_i.we ? '0 : rd_data;
    end
  end

  assign rsp_o.gnt    = req_i.req;
  assign rsp_o.rvalid = rvalid_q;
  assign rsp_o.rdata  = rdata_q;

  for (genvar d = 0; d < NUM_DOMAINS; d++) begin : gen_domain
    power_domain_seq i_power_domain_seq (
      .clk_i,
      .rst_n_i,
      .off_req_i(off_req_q[d]),
      .ack_n_i  (switch_ack_n_i[d]),
      .ctrl_o   (pwr_ctrl_o[d]),
      .is_off_o (is_off[d]),
      .is_on_o  (is_on[d])
    );
  end

endmodule

// File: power_ctrl/power_domain_seq.sv
//////////////////////////////////////////////////
// power domain sequencer
// isolate, switch and reset with switch ack wait
//////////////////////////////////////////////////

`timescale 1ns/1ns

module power_domain_seq (
  input  logic                      clk_i,
  input  logic                      rst_n_i,
  input  logic                      off_req_i,
  input  logic                      ack_n_i,
  output ext_subsys_pkg::pwr_ctrl_t ctrl_o,
  output logic                      is_off_o,
  output logic                      is_on_o
);
  import ext_subsys_pkg::*;

  pwr_state_e state_q;
  pwr_state_e state_d;

  always_comb begin
    state_d = state_q;
    case (state_q)
      // request changes are only taken in the stable states
      PWR_ON: begin
        if (off_req_i) begin
          state_d = PWR_ISO;
        end
      end
      PWR_ISO: state_d = PWR_SW_OFF;
      PWR_SW_OFF: begin
        if (ack_n_i) begin
          state_d = PWR_OFF;
        end
      end
      PWR_OFF: begin
        if (!off_req_i) begin
          state_d = PWR_SW_ON;
        end
      end
      // switch cells report power good by pulling ack low
      PWR_SW_ON: begin
        if (!ack_n_i) begin
          state_d = PWR_UNISO;
        end
      end
      PWR_UNISO:   state_d = PWR_RST_REL;
      PWR_RST_REL: state_d = PWR_ON;
      default:     state_d = PWR_ON;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state_q <= PWR_ON;
    end else begin
      state_q <= state_d;
    end
  end

  // reset goes low together with isolation
  always_comb begin
    case (state_q)
      PWR_ISO:             ctrl_o = '{switch_n: 1'b0, iso_n: 1'b0, rst_n: 1'b0};
      PWR_SW_OFF, PWR_OFF: ctrl_o = '{switch_n: 1'b1, iso_n: 1'b0, rst_n: 1'b0};
      PWR_SW_ON:           ctrl_o = '{switch_n: 1'b0, iso_n: 1'b0, rst_n: 1'b0};
      PWR_UNISO:           ctrl_o = '{switch_n: 1'b0, iso_n: 1'b1, rst_n: 1'b0};
      default:             ctrl_o = '{switch_n: 1'b0, iso_n: 1'b1, rst_n: 1'b1};
    endcase
  end

  assign is_off_o = (state_q == PWR_OFF);
  assign is_on_o  = (state_q == PWR_ON);

endmodule

// File: rtl/ext_subsys.sv
//////////////////////////////////////////////////
// external subsystem top level
// demux, slow memory and power controller
//////////////////////////////////////////////////

`timescale 1ns/1ns

module ext_subsys #(
  parameter int unsigned MEM_WORDS   = 1024,
  parameter int unsigned MEM_LATENCY = 2,
  parameter int unsigned NUM_DOMAINS = 2
) (
  input  logic                                        clk_i,
  input  logic                                        rst_n_i,
  input  ext_subsys_pkg::obi_req_t                    host_req_i,
  output ext_subsys_pkg::obi_rsp_t                    host_rsp_o,
  output ext_subsys_pkg::pwr_ctrl_t [NUM_DOMAINS-1:0] pwr_ctrl_o,
  input  logic [NUM_DOMAINS-1:0]                      switch_ack_n_i
);
  import ext_subsys_pkg::*;

  obi_req_t mem_req;
  obi_rsp_t mem_rsp;
  obi_req_t pwr_req;
  obi_rsp_t pwr_rsp;

  obi_demux i_obi_demux (
    .clk_i,
    .rst_n_i,
    .host_req_i,
    .host_rsp_o,
    .mem_req_o(mem_req),
    .mem_rsp_i(mem_rsp),
    .pwr_req_o(pwr_req),
    .pwr_rsp_i(pwr_rsp)
  );

  // default target for every address outside the power window
  slow_mem #(
    .MEM_WORDS  (MEM_WORDS),
    .MEM_LATENCY(MEM_LATENCY)
  ) i_slow_mem (
    .clk_i,
    .rst_n_i,
    .req_i(mem_req),
    .rsp_o(mem_rsp)
  );

  power_ctrl_regs #(
    .NUM_DOMAINS(NUM_DOMAINS)
  ) i_power_ctrl_regs (
    .clk_i,
    .rst_n_i,
    .req_i(pwr_req),
    .rsp_o(pwr_rsp),
    .pwr_ctrl_o,
    .switch_ack_n_i
  );

endmodule

// File: rtl/obi_demux.sv
//////////////////////////////////////////////////
// host port demux
// steers requests to memory or power regs and
// returns responses in grant order
//////////////////////////////////////////////////

`timescale 1ns/1ns

module obi_demux (
  input  logic                     clk_i,
  input  logic                     rst_n_i,
  input  ext_subsys_pkg::obi_req_t host_req_i,
  output ext_subsys_pkg::obi_rsp_t host_rsp_o,
  output ext_subsys_pkg::obi_req_t mem_req_o,
  input  ext_subsys_pkg::obi_rsp_t mem_rsp_i,
  output ext_subsys_pkg::obi_req_t pwr_req_o,
  input  ext_subsys_pkg::obi_rsp_t pwr_rsp_i
);
  import ext_subsys_pkg::*;

  localparam int unsigned MAX_OUTSTANDING = 4;
  localparam int unsigned CNT_W           = $clog2(MAX_OUTSTANDING + 1);

  target_e          sel;
  target_e          last_tgt_q;
  logic [CNT_W-1:0] out_cnt_q;
  logic             may_issue;
  logic             accept;
  logic             retire;
  obi_rsp_t         owner_rsp;

  // single rule for the power window, default goes to memory
  assign sel = ((host_req_i.addr & PWR_MASK) == PWR_BASE) ? TGT_PWR : TGT_MEM;

  // only one target in flight at a time, so no reordering needed
  assign may_issue = (out_cnt_q < CNT_W'(MAX_OUTSTANDING)) &&
                     ((out_cnt_q == '0) || (last_tgt_q == sel));

  always_comb begin
    mem_req_o     = host_req_i;
    pwr_req_o     = host_req_i;
    mem_req_o.req = host_req_i.req & may_issue & (sel == TGT_MEM);
    pwr_req_o.req = host_req_i.req & may_issue & (sel == TGT_PWR);
  end

  // responses come from whoever owns the outstanding transactions
  assign owner_rsp = (last_tgt_q == TGT_PWR) ? pwr_rsp_i : mem_rsp_i;

  always_comb begin
    host_rsp_o.gnt    = host_req_i.req & may_issue &
                        ((sel == TGT_PWR) ? pwr_rsp_i.gnt : mem_rsp_i.gnt);
    host_rsp_o.rvalid = owner_rsp.rvalid;
    host_rsp_o.rdata  = owner_rsp.rdata;
  end

  assign accept = host_req_i.req & host_rsp_o.gnt;
  assign retire = host_rsp_o.rvalid;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      out_cnt_q  <= '0;
      last_tgt_q <= TGT_MEM;
    end else begin
      out_cnt_q <= out_cnt_q + CNT_W'(accept) - CNT_W'(retire);
      if (accept) begin
        last_tgt_q <= sel;
      end
    end
  end

endmodule

// File: slow_mem/slow_mem.sv
//////////////////////////////////////////////////
// slow memory target
// FIFO, byte-enable word array, fixed read latency
//////////////////////////////////////////////////

`timescale 1ns/1ns

module slow_mem #(
  parameter int unsigned MEM_WORDS   = 1024,
  parameter int unsigned MEM_LATENCY = 2
) (
  input  logic                     clk_i,
  input  logic                     rst_n_i,
  input  ext_subsys_pkg::obi_req_t req_i,
  output ext_subsys_pkg::obi_rsp_t rsp_o
);
  import ext_subsys_pkg::*;

  // depth is a power of two, so the index wraps by slicing
  localparam int unsigned IDX_W = $clog2(MEM_WORDS);

  obi_req_t          head;
  logic              fifo_gnt;
  logic [IDX_W-1:0]  idx;
  logic [DATA_W-1:0] mem_q [MEM_WORDS];
  logic [DATA_W-1:0] rd_word;
  logic              valid_q [MEM_LATENCY];
  logic [DATA_W-1:0] data_q  [MEM_LATENCY];

  slow_mem_fifo i_slow_mem_fifo (
    .clk_i,
    .rst_n_i,
    .in_req_i (req_i),
    .in_gnt_o (fifo_gnt),
    .out_req_o(head),
    .out_pop_i(head.req)
  );

  // word address sits above the byte offset
  assign idx = head.addr[IDX_W+1:2];

  // writes return zero data
  assign rd_word = head.we ? '0 : mem_q[idx];

  always_ff @(posedge clk_i) begin
    if (head.req && head.we) begin
      for (int b = 0; b < BE_W; b++) begin
        if (head.be[b]) begin
          mem_q[idx][8*b +: 8] <= head.wdata[8*b +: 8];
        end
      end
    end
  end

  // latency line, one stage per cycle
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      for (int s = 0; s < MEM_LATENCY; s++) begin
        valid_q[s] <= 1'b0;
      end
    end else begin
      valid_q[0] <= head.req;
      for (int s = 1; s < MEM_LATENCY; s++) begin
        valid_q[s] <= valid_q[s-1];
      end
    end
  end

  always_ff @(posedge clk_i) begin
    data_q[0] <= rd_word;
    for (int s = 1; s < MEM_LATENCY; s++) begin
      data_q[s] <= data_q[s-1];
    end
  end

  assign rsp_o.gnt    = fifo_gnt;
  assign rsp_o.rvalid = valid_q[MEM_LATENCY-1];
  assign rsp_o.rdata  = data_q[MEM_LATENCY-1];

endmodule

// File: slow_mem/slow_mem_fifo.sv
//////////////////////////////////////////////////
// slow memory request FIFO
// two entries, adds one cycle in front of array
//////////////////////////////////////////////////

`timescale 1ns/1ns

module slow_mem_fifo (
  input  logic                     clk_i,
  input  logic                     rst_n_i,
  input  ext_subsys_pkg::obi_req_t in_req_i,
  output logic                     in_gnt_o,
  output ext_subsys_pkg::obi_req_t out_req_o,
  input  logic                     out_pop_i
);
  import ext_subsys_pkg::*;

  localparam int unsigned DEPTH = 2;
  localparam int unsigned PTR_W = $clog2(DEPTH);
  localparam int unsigned CNT_W = $clog2(DEPTH + 1);

  obi_req_t         entry_q [DEPTH];
  logic [PTR_W-1:0] wr_ptr_q;
  logic [PTR_W-1:0] rd_ptr_q;
  logic [CNT_W-1:0] count_q;
  logic             full;
  logic             empty;
  logic             push;
  logic             pop;

  assign full  = (count_q == CNT_W'(DEPTH));
  assign empty = (count_q == '0);
  assign push  = in_req_i.req & ~full;
  assign pop   = out_pop_i & ~empty;

  assign in_gnt_o = ~full;

  always_comb begin
    out_req_o     = entry_q[rd_ptr_q];
    out_req_o.req = ~empty;
  end

  // pointers and fill level
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push) begin
        wr_ptr_q <= wr_ptr_q + 1'b1;
      end
      if (pop) begin
        rd_ptr_q <= rd_ptr_q + 1'b1;
      end
      count_q <= count_q + CNT_W'(push) - CNT_W'(pop);
    end
  end

  always_ff @(posedge clk_i) begin
    if (push) begin
      entry_q[wr_ptr_q] <= in_req_i;
    end
  end

endmodule

// File: tb.f
common/ext_subsys_pkg.sv
rtl/obi_demux.sv
slow_mem/slow_mem_fifo.sv
slow_mem/slow_mem.sv
power_ctrl/power_domain_seq.sv
power_ctrl/power_ctrl_regs.sv
rtl/ext_subsys.sv
dv/ext_subsys_checker.sv
dv/tb_ext_subsys.sv
